// File: common/decomp_cfg_pkg.sv
package decomp_cfg_pkg;

	// input FIFO, must stay a power of two so the pointers wrap on their own
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = 4;

	// history window of 2048 bytes
	localparam int HIST_AW = 11;

	// one data byte on every stream
	typedef logic [7:0] byte_t;

	// job length in bytes, compressed or decompressed
	typedef logic [31:0] len_t;

	// position in the history, also used for copy offsets
	typedef logic [HIST_AW-1:0] hist_addr_t;

	// run length of a literal or copy, 1 to 64
	typedef logic [6:0] copy_len_t;

endpackage

// File: common/snappy_tag_pkg.sv
package snappy_tag_pkg;

	// longest literal that fits in the tag byte itself
	localparam int MAX_SHORT_LIT = 60;

	// copy1 stores length minus 4 in three bits
	localparam int COPY1_MIN_LEN = 4;

	// low two bits of every tag byte
	typedef enum logic [1:0] {
		TAG_LITERAL = 2'b00,
		TAG_COPY1   = 2'b01,
		TAG_COPY2   = 2'b10,
		TAG_COPY4   = 2'b11
	} tag_e;

	// what the parser hands to the history buffer
	typedef enum logic {
		CMD_LIT  = 1'b0,
		CMD_COPY = 1'b1
	} cmd_kind_e;

	typedef enum logic [2:0] {
		ST_TAG,      // waiting for a tag byte
		ST_LIT_BODY, // forwarding literal bytes
		ST_OFF_LO,   // first offset byte
		ST_OFF_HI,   // second offset byte, copy2 only
		ST_ISSUE     // copy command waits for a free slot
	} parse_state_e;

endpackage

// File: logic/input_fifo.sv
`timescale 1ns/1ns

module input_fifo (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  flush_i,
	input  decomp_cfg_pkg::byte_t data_i,
	input  logic                  push_i,
	input  logic                  pop_i,
	output decomp_cfg_pkg::byte_t data_o,
	output logic                  empty_o,
	output logic                  almost_full_o
);

	decomp_cfg_pkg::byte_t              mem [decomp_cfg_pkg::FIFO_DEPTH];
	logic [decomp_cfg_pkg::FIFO_AW-1:0] rd_ptr;
	logic [decomp_cfg_pkg::FIFO_AW-1:0] wr_ptr;
	logic [decomp_cfg_pkg::FIFO_AW:0]   count;

	assign data_o = mem[rd_ptr]; // head is always visible
	assign empty_o = (count == '0);

	// fewer than two free entries left
	assign almost_full_o =
		(count >= (decomp_cfg_pkg::FIFO_AW + 1)'(decomp_cfg_pkg::FIFO_DEPTH - 1));

	always_ff @(posedge clk) begin
		if (push_i)
			mem[wr_ptr] <= data_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || flush_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// source must honour almost_full, parser must honour empty
	assert property (@(posedge clk) disable iff (!rst_n)
		!(push_i && count == (decomp_cfg_pkg::FIFO_AW + 1)'(decomp_cfg_pkg::FIFO_DEPTH)));
	assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o);

endmodule

// File: parser/token_parser.sv
`timescale 1ns/1ns

module token_parser (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        en_i,
	input  decomp_cfg_pkg::byte_t       fifo_data_i,
	input  logic                        fifo_empty_i,
	output logic                        fifo_pop_o,
	output logic                        cmd_valid_o,
	output snappy_tag_pkg::cmd_kind_e   cmd_kind_o,
	output decomp_cfg_pkg::byte_t       cmd_byte_o,
	output decomp_cfg_pkg::hist_addr_t  cmd_offset_o,
	output decomp_cfg_pkg::copy_len_t   cmd_len_o,
	input  logic                        cmd_ready_i
);

	snappy_tag_pkg::parse_state_e state;
	snappy_tag_pkg::tag_e         tag_type;
	decomp_cfg_pkg::copy_len_t    lit_rem;  // literal bytes still to forward
	decomp_cfg_pkg::copy_len_t    copy_len;
	decomp_cfg_pkg::hist_addr_t   copy_off;
	logic                         is_copy2;
	logic                         slot_free;
	logic                         can_pop;
	logic                         issue_lit;
	logic                         issue_copy;

	assign tag_type = snappy_tag_pkg::tag_e'(fifo_data_i[1:0]);
	assign slot_free = !cmd_valid_o || cmd_ready_i; // cmd register empty or emptying
	assign can_pop = en_i && !fifo_empty_i;

	always_comb begin
		case (state)
			snappy_tag_pkg::ST_TAG,
			snappy_tag_pkg::ST_OFF_LO,
			snappy_tag_pkg::ST_OFF_HI:   fifo_pop_o = can_pop;
			snappy_tag_pkg::ST_LIT_BODY: fifo_pop_o = can_pop && slot_free;
			default:                     fifo_pop_o = 1'b0;
		endcase
	end

	assign issue_lit = (state == snappy_tag_pkg::ST_LIT_BODY) && fifo_pop_o;
	assign issue_copy = (state == snappy_tag_pkg::ST_ISSUE) && slot_free;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= snappy_tag_pkg::ST_TAG;
			cmd_valid_o <= 1'b0;
			lit_rem     <= '0;
		end else begin
			if (issue_lit || issue_copy)
				cmd_valid_o <= 1'b1;
			else if (cmd_ready_i)
				cmd_valid_o <= 1'b0;

			case (state)
				snappy_tag_pkg::ST_TAG: begin
					if (fifo_pop_o) begin
						case (tag_type)
							snappy_tag_pkg::TAG_LITERAL: begin
								// long literals are not supported, tag is skipped
								if (fifo_data_i[7:2] < 6'(snappy_tag_pkg::MAX_SHORT_LIT)) begin
									lit_rem <= decomp_cfg_pkg::copy_len_t'(fifo_data_i[7:2]) + 1'b1;
									state   <= snappy_tag_pkg::ST_LIT_BODY;
								end
							end
							snappy_tag_pkg::TAG_COPY1,
							snappy_tag_pkg::TAG_COPY2: state <= snappy_tag_pkg::ST_OFF_LO;
							default: state <= snappy_tag_pkg::ST_TAG; // copy4 dropped
						endcase
					end
				end
				snappy_tag_pkg::ST_LIT_BODY: begin
					if (fifo_pop_o) begin
						lit_rem <= lit_rem - 1'b1;
						if (lit_rem == decomp_cfg_pkg::copy_len_t'(1))
							state <= snappy_tag_pkg::ST_TAG;
					end
				end
				snappy_tag_pkg::ST_OFF_LO: begin
					if (fifo_pop_o)
						state <= is_copy2 ? snappy_tag_pkg::ST_OFF_HI : snappy_tag_pkg::ST_ISSUE;
				end
				snappy_tag_pkg::ST_OFF_HI: begin
					if (fifo_pop_o)
						state <= snappy_tag_pkg::ST_ISSUE;
				end
				default: begin
					if (issue_copy)
						state <= snappy_tag_pkg::ST_TAG;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == snappy_tag_pkg::ST_TAG && fifo_pop_o) begin
			is_copy2 <= (tag_type == snappy_tag_pkg::TAG_COPY2);
			copy_off <= {fifo_data_i[7:5], 8'h00}; // copy1 high offset bits
			if (tag_type == snappy_tag_pkg::TAG_COPY1)
				copy_len <= decomp_cfg_pkg::copy_len_t'(fifo_data_i[4:2])
					+ decomp_cfg_pkg::copy_len_t'(snappy_tag_pkg::COPY1_MIN_LEN);
			else
				copy_len <= decomp_cfg_pkg::copy_len_t'(fifo_data_i[7:2]) + 1'b1;
		end
		if (state == snappy_tag_pkg::ST_OFF_LO && fifo_pop_o)
			copy_off[7:0] <= fifo_data_i;
		if (state == snappy_tag_pkg::ST_OFF_HI && fifo_pop_o)
			copy_off[decomp_cfg_pkg::HIST_AW-1:8] <= fifo_data_i[decomp_cfg_pkg::HIST_AW-9:0];

		if (issue_lit) begin
			cmd_kind_o   <= snappy_tag_pkg::CMD_LIT;
			cmd_byte_o   <= fifo_data_i;
			cmd_offset_o <= '0;
			cmd_len_o    <= decomp_cfg_pkg::copy_len_t'(1);
		end else if (issue_copy) begin
			cmd_kind_o   <= snappy_tag_pkg::CMD_COPY;
			cmd_offset_o <= copy_off;
			cmd_len_o    <= copy_len;
		end
	end

	// a zero offset would read a byte not yet written
	assert property (@(posedge clk) disable iff (!rst_n)
		(cmd_valid_o && cmd_kind_o == snappy_tag_pkg::CMD_COPY)
		|-> (cmd_len_o != '0 && cmd_offset_o != '0));

endmodule

// File: history/history_buffer.sv
`timescale 1ns/1ns

module history_buffer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        cmd_valid_i,
	input  snappy_tag_pkg::cmd_kind_e   cmd_kind_i,
	input  decomp_cfg_pkg::byte_t       cmd_byte_i,
	input  decomp_cfg_pkg::hist_addr_t  cmd_offset_i,
	input  decomp_cfg_pkg::copy_len_t   cmd_len_i,
	output logic                        cmd_ready_o,
	output decomp_cfg_pkg::byte_t       data_o,
	output logic                        valid_o,
	input  logic                        ready_i,
	output logic                        fire_o
);

	decomp_cfg_pkg::byte_t      mem [2**decomp_cfg_pkg::HIST_AW];
	decomp_cfg_pkg::hist_addr_t wr_ptr;    // next position to write
	decomp_cfg_pkg::hist_addr_t copy_off;
	decomp_cfg_pkg::copy_len_t  copy_rem;  // copy bytes still to emit
	decomp_cfg_pkg::hist_addr_t rd_addr;
	decomp_cfg_pkg::byte_t      new_byte;
	logic                       adv;
	logic                       expanding;
	logic                       cmd_fire;
	logic                       load_byte;

	assign adv = !valid_o || ready_i; // output register can take a byte
	assign expanding = (copy_rem != '0);
	assign cmd_ready_o = !expanding && adv;
	assign cmd_fire = cmd_valid_i && cmd_ready_o;
	assign load_byte = cmd_fire || (expanding && adv);
	assign fire_o = valid_o && ready_i;

	// first copy byte uses the offset straight from the command
	assign rd_addr = wr_ptr - (expanding ? copy_off : cmd_offset_i);
	assign new_byte = (cmd_fire && cmd_kind_i == snappy_tag_pkg::CMD_LIT) ? cmd_byte_i
		: mem[rd_addr];

	// write back every emitted byte so overlapping copies see it next cycle
	always_ff @(posedge clk) begin
		if (load_byte) begin
			mem[wr_ptr] <= new_byte;
			data_o      <= new_byte;
		end
		if (cmd_fire)
			copy_off <= cmd_offset_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			copy_rem <= '0;
			valid_o  <= 1'b0;
		end else begin
			if (load_byte)
				wr_ptr <= wr_ptr + 1'b1;

			if (cmd_fire && cmd_kind_i == snappy_tag_pkg::CMD_COPY)
				copy_rem <= cmd_len_i - 1'b1;
			else if (expanding && adv)
				copy_rem <= copy_rem - 1'b1;

			if (load_byte)
				valid_o <= 1'b1;
			else if (ready_i)
				valid_o <= 1'b0;
		end
	end

	// a stalled byte must not change under the sink
	assert property (@(posedge clk) disable iff (!rst_n)
		(valid_o && !ready_i) |=> (valid_o && $stable(data_o)));

endmodule

// File: logic/job_control.sv
`timescale 1ns/1ns

module job_control (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start_i,
	input  decomp_cfg_pkg::len_t comp_len_i,
	input  decomp_cfg_pkg::len_t decomp_len_i,
	input  logic                 pop_i,
	input  logic                 out_fire_i,
	output logic                 parse_en_o,
	output logic                 flush_o,
	output logic                 last_o,
	output logic                 done_o
);

	decomp_cfg_pkg::len_t comp_len;
	decomp_cfg_pkg::len_t decomp_len;
	decomp_cfg_pkg::len_t consumed;  // bytes popped from the FIFO
	decomp_cfg_pkg::len_t emitted;   // bytes accepted by the sink
	logic                 active;

	assign flush_o = start_i; // drop stale input from an earlier job
	assign parse_en_o = active && (consumed < comp_len);
	assign last_o = active && (emitted == decomp_len - 1'b1);

	always_ff @(posedge clk) begin
		if (start_i) begin
			comp_len   <= comp_len_i;
			decomp_len <= decomp_len_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			consumed <= '0;
			emitted  <= '0;
			active   <= 1'b0;
			done_o   <= 1'b0;
		end else if (start_i) begin
			consumed <= '0;
			emitted  <= '0;
			active   <= 1'b1;
			done_o   <= 1'b0;
		end else begin
			if (pop_i)
				consumed <= consumed + 1'b1;
			if (out_fire_i) begin
				emitted <= emitted + 1'b1;
				if (last_o) begin // final byte leaves this cycle
					active <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

	// lengths and counters are only reloaded between jobs
	assert property (@(posedge clk) disable iff (!rst_n) start_i |-> !active);

endmodule

// File: logic/decompressor.sv
`timescale 1ns/1ns

module decompressor (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start_i,
	input  decomp_cfg_pkg::len_t  comp_len_i,
	input  decomp_cfg_pkg::len_t  decomp_len_i,
	input  decomp_cfg_pkg::byte_t data_i,
	input  logic                  valid_i,
	output logic                  almost_full_o,
	output decomp_cfg_pkg::byte_t data_o,
	output logic                  valid_o,
	input  logic                  ready_i,
	output logic                  last_o,
	output logic                  done_o
);

	decomp_cfg_pkg::byte_t      fifo_data;
	decomp_cfg_pkg::byte_t      cmd_byte;
	decomp_cfg_pkg::hist_addr_t cmd_offset;
	decomp_cfg_pkg::copy_len_t  cmd_len;
	snappy_tag_pkg::cmd_kind_e  cmd_kind;
	logic                       fifo_push;
	logic                       fifo_pop;
	logic                       fifo_empty;
	logic                       parse_en;
	logic                       flush;
	logic                       cmd_valid;
	logic                       cmd_ready;
	logic                       out_fire;
	logic                       job_last;

	assign fifo_push = valid_i && !almost_full_o; // valid/almost-full handshake
	assign last_o = job_last && valid_o;

	input_fifo u_fifo (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush_i       (flush),
		.data_i        (data_i),
		.push_i        (fifo_push),
		.pop_i         (fifo_pop),
		.data_o        (fifo_data),
		.empty_o       (fifo_empty),
		.almost_full_o (almost_full_o)
	);

	token_parser u_parser (
		.clk          (clk),
		.rst_n        (rst_n),
		.en_i         (parse_en),
		.fifo_data_i  (fifo_data),
		.fifo_empty_i (fifo_empty),
		.fifo_pop_o   (fifo_pop),
		.cmd_valid_o  (cmd_valid),
		.cmd_kind_o   (cmd_kind),
		.cmd_byte_o   (cmd_byte),
		.cmd_offset_o (cmd_offset),
		.cmd_len_o    (cmd_len),
		.cmd_ready_i  (cmd_ready)
	);

	history_buffer u_history (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd_valid_i  (cmd_valid),
		.cmd_kind_i   (cmd_kind),
		.cmd_byte_i   (cmd_byte),
		.cmd_offset_i (cmd_offset),
		.cmd_len_i    (cmd_len),
		.cmd_ready_o  (cmd_ready),
		.data_o       (data_o),
		.valid_o      (valid_o),
		.ready_i      (ready_i),
		.fire_o       (out_fire)
	);

	job_control u_job (
		.clk          (clk),
		.rst_n        (rst_n),
		.start_i      (start_i),
		.comp_len_i   (comp_len_i),
		.decomp_len_i (decomp_len_i),
		.pop_i        (fifo_pop),
		.out_fire_i   (out_fire),
		.parse_en_o   (parse_en),
		.flush_o      (flush),
		.last_o       (job_last),
		.done_o       (done_o)
	);

endmodule

// File: tb/snappy_ref.svh
`ifndef SNAPPY_REF_SVH
`define SNAPPY_REF_SVH

logic [31:0] rng = 32'h3fe0fdfc;

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// next random number in 0 .. n-1
function automatic int rand_below(input int n);
	rng = xorshift(rng);
	return int'(rng % 32'(n));
endfunction

// literal tag plus len random bytes, len 1 to 60
function automatic void put_literal(ref decomp_cfg_pkg::byte_t comp[$], input int len);
	comp.push_back({6'(len - 1), snappy_tag_pkg::TAG_LITERAL});
	for (int k = 0; k < len; k++)
		comp.push_back(decomp_cfg_pkg::byte_t'(rand_below(256)));
endfunction

// len 4 to 11, offset up to 2047
function automatic void put_copy1(ref decomp_cfg_pkg::byte_t comp[$], input int off, input int len);
	logic [15:0] o;
	o = 16'(off);
	comp.push_back({o[10:8], 3'(len - snappy_tag_pkg::COPY1_MIN_LEN), snappy_tag_pkg::TAG_COPY1});
	comp.push_back(o[7:0]);
endfunction

// len 1 to 64, offset little endian
function automatic void put_copy2(ref decomp_cfg_pkg::byte_t comp[$], input int off, input int len);
	logic [15:0] o;
	o = 16'(off);
	comp.push_back({6'(len - 1), snappy_tag_pkg::TAG_COPY2});
	comp.push_back(o[7:0]);
	comp.push_back(o[15:8]);
endfunction

// random legal stream, copies only reach back into bytes already produced
function automatic void gen_stream(ref decomp_cfg_pkg::byte_t comp[$], input int ntok);
	int produced;
	int kind;
	int len;
	int span;
	produced = 0;
	comp.delete();
	for (int t = 0; t < ntok; t++) begin
		kind = (produced == 0) ? 0 : rand_below(3);
		span = (produced < 2047) ? produced : 2047;
		case (kind)
			0: begin
				len = 1 + rand_below(60);
				put_literal(comp, len);
			end
			1: begin
				len = 4 + rand_below(8);
				put_copy1(comp, 1 + rand_below(span), len);
			end
			default: begin
				len = 1 + rand_below(64);
				put_copy2(comp, 1 + rand_below(span), len);
			end
		endcase
		produced += len;
	end
endfunction

// plain software decoder, copies go byte by byte so overlaps repeat
function automatic void ref_decode(ref decomp_cfg_pkg::byte_t comp[$],
		ref decomp_cfg_pkg::byte_t out[$]);
	int i;
	int len;
	int off;
	decomp_cfg_pkg::byte_t tag;
	out.delete();
	i = 0;
	while (i < comp.size()) begin
		tag = comp[i];
		i++;
		off = 0;
		case (snappy_tag_pkg::tag_e'(tag[1:0]))
			snappy_tag_pkg::TAG_LITERAL: begin
				len = int'(tag[7:2]) + 1;
				for (int k = 0; k < len; k++)
					out.push_back(comp[i + k]);
				i += len;
			end
			snappy_tag_pkg::TAG_COPY1: begin
				len = int'(tag[4:2]) + snappy_tag_pkg::COPY1_MIN_LEN;
				off = int'({tag[7:5], comp[i]});
				i += 1;
			end
			default: begin // copy2, copy4 never generated
				len = int'(tag[7:2]) + 1;
				off = int'({comp[i + 1], comp[i]});
				i += 2;
			end
		endcase
		if (off != 0) begin
			for (int k = 0; k < len; k++)
				out.push_back(out[out.size() - off]);
		end
	end
endfunction

`endif

// File: tb/tb_decompressor.sv
`timescale 1ns/1ns

module tb_decompressor;

	logic                  clk;
	logic                  rst_n;
	logic                  start_i;
	decomp_cfg_pkg::len_t  comp_len_i;
	decomp_cfg_pkg::len_t  decomp_len_i;
	decomp_cfg_pkg::byte_t data_i;
	logic                  valid_i;
	logic                  almost_full_o;
	decomp_cfg_pkg::byte_t data_o;
	logic                  valid_o;
	logic                  ready_i;
	logic                  last_o;
	logic                  done_o;

	`include "snappy_ref.svh"

	decomp_cfg_pkg::byte_t comp_q[$];
	decomp_cfg_pkg::byte_t exp_q[$];  // expected output of the running job
	string                 test_name;
	int                    out_idx;
	int                    errors = 0;
	int                    checks = 0;
	int                    ntests = 0;
	int                    cycles = 0;
	int                    limit = 500;

	decompressor uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.start_i      (start_i),
		.comp_len_i   (comp_len_i),
		.decomp_len_i (decomp_len_i),
		.data_i       (data_i),
		.valid_i      (valid_i),
		.almost_full_o(almost_full_o),
		.data_o       (data_o),
		.valid_o      (valid_o),
		.ready_i      (ready_i),
		.last_o       (last_o),
		.done_o       (done_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_byte(input string name, input decomp_cfg_pkg::byte_t exp,
			input decomp_cfg_pkg::byte_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_len(input string name, input decomp_cfg_pkg::len_t exp,
			input decomp_cfg_pkg::len_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected %0d, got %0d", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected %b, got %b", name, exp, act);
		end
	endtask

	// outputs are stable at the falling edge ahead of the transfer
	always @(negedge clk) begin
		if (rst_n && valid_o && ready_i) begin
			if (out_idx >= exp_q.size()) begin
				errors++;
				$display("%s: byte %0d sent beyond the expected %0d", test_name, out_idx,
					exp_q.size());
			end else begin
				check_byte($sformatf("%s byte %0d", test_name, out_idx), exp_q[out_idx], data_o);
				check_flag($sformatf("%s last %0d", test_name, out_idx),
					out_idx == exp_q.size() - 1, last_o);
			end
			out_idx++;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout: %s did not finish within %0d cycles", test_name, limit);
			$display("tests failed");
			$finish;
		end
	end

	// runs one job with input gaps and output stalls until done
	task automatic run_job(input string name, input int gap_pct, input int stall_pct);
		int idx;
		int err0;
		logic take;
		ref_decode(comp_q, exp_q);
		test_name = name;
		out_idx = 0;
		err0 = errors;
		idx = 0;
		take = 1'b0;
		limit = cycles + 40 * (comp_q.size() + exp_q.size()) + 500;
		start_i = 1'b1;
		comp_len_i = decomp_cfg_pkg::len_t'(comp_q.size());
		decomp_len_i = decomp_cfg_pkg::len_t'(exp_q.size());
		@(posedge clk);
		#1;
		start_i = 1'b0;
		check_flag({name, " done cleared"}, 1'b0, done_o);
		while (!done_o && out_idx < exp_q.size()) begin
			if (take)
				idx++;
			valid_i = (idx < comp_q.size()) && (rand_below(100) >= gap_pct);
			data_i = valid_i ? comp_q[idx] : 8'h00;
			take = valid_i && !almost_full_o; // almost_full_o holds until the edge
			ready_i = (rand_below(100) >= stall_pct);
			@(posedge clk);
			#1;
		end
		// done follows the final byte by one cycle
		check_flag({name, " done after last"}, 1'b1, done_o);
		check_len({name, " count"}, decomp_cfg_pkg::len_t'(exp_q.size()),
			decomp_cfg_pkg::len_t'(out_idx));
		valid_i = 1'b0;
		ready_i = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		check_flag({name, " done held"}, 1'b1, done_o);
		ntests++;
		if (errors == err0)
			$display("test %s: ok, %0d bytes", name, out_idx);
		else
			$display("test %s: %0d errors", name, errors - err0);
	endtask

	initial begin
		rst_n = 1'b0;
		start_i = 1'b0;
		comp_len_i = '0;
		decomp_len_i = '0;
		data_i = '0;
		valid_i = 1'b0;
		ready_i = 1'b1;
		test_name = "reset";
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_flag("reset valid_o", 1'b0, valid_o);
		check_flag("reset last_o", 1'b0, last_o);
		check_flag("reset done_o", 1'b0, done_o);
		check_flag("reset almost_full_o", 1'b0, almost_full_o);
		ntests++;
		$display("test reset: %0d errors", errors);

		comp_q.delete();
		put_literal(comp_q, 1);
		put_literal(comp_q, 17);
		put_literal(comp_q, 60);
		run_job("literals", 0, 0);

		comp_q.delete();
		put_literal(comp_q, 1);
		put_copy1(comp_q, 1, 11);  // run of 12 equal bytes
		put_literal(comp_q, 3);
		put_copy1(comp_q, 3, 8);
		run_job("overlap copy1", 0, 0);

		comp_q.delete();
		repeat (25) put_literal(comp_q, 60);
		put_copy2(comp_q, 1400, 64);
		run_job("far copy2", 0, 0);

		for (int t = 0; t < 4; t++) begin
			gen_stream(comp_q, 40);
			run_job($sformatf("random %0d", t), 30, 40);
		end

		// back to back jobs check last and done framing
		gen_stream(comp_q, 12);
		run_job("framing first", 0, 20);
		gen_stream(comp_q, 12);
		run_job("framing second", 10, 0);

		$display("%0d tests, %0d checks, %0d errors", ntests, checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+tb
common/decomp_cfg_pkg.sv
common/snappy_tag_pkg.sv
logic/input_fifo.sv
parser/token_parser.sv
history/history_buffer.sv
logic/job_control.sv
logic/decompressor.sv
tb/tb_decompressor.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_decompressor
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
